// File: verilog/opl3_phase_pkg.sv
package opl3_phase_pkg;

    // ------------------------------------------------------------------------
    // Widths and slot constants
    // ------------------------------------------------------------------------
    localparam int PHASE_ACC_WIDTH  = 19;    // Phase accumulator word.
    localparam int BANK_NUM_WIDTH   = 1;     // Two banks of operators.
    localparam int OP_NUM_WIDTH     = 5;     // Operator 0 to 17 within a bank.
    localparam int NUM_OPS_PER_BANK = 18;    // Operators in one bank.
    localparam int NUM_SLOTS        = 36;    // Slots visited in one sample sweep.
    localparam int SLOT_WIDTH       = 6;     // Flat index, bank * 18 + operator.
    localparam int FNUM_WIDTH       = 10;    // Frequency number.
    localparam int BLOCK_WIDTH      = 3;     // Octave block, a left shift of fnum.
    localparam int MULT_WIDTH       = 4;     // Frequency multiple code.

    // Noise generator, a right shifting Galois LFSR.
    localparam int RAND_NUM_WIDTH = 23;
    localparam logic [RAND_NUM_WIDTH-1:0] RAND_POLYNOMIAL = 23'h800302;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    // How the rhythm section treats a slot.
    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BASS_DRUM,
        OP_HI_HAT,
        OP_TOM_TOM,
        OP_SNARE_DRUM,
        OP_TOP_CYMBAL
    } operator_t;

    // One configuration word, 17 bits.
    typedef struct packed {
        logic [FNUM_WIDTH-1:0]  fnum;     // Frequency number.
        logic [BLOCK_WIDTH-1:0] block;    // Octave, shifts fnum left.
        logic [MULT_WIDTH-1:0]  mult;     // Multiple, 0 means one half.
    } op_cfg_t;

    // The slot occupying a pipeline stage.
    typedef struct packed {
        logic                      en;          // Slot strobe for this stage.
        logic [BANK_NUM_WIDTH-1:0] bank_num;
        logic [OP_NUM_WIDTH-1:0]   op_num;
        operator_t                 op_type;     // Rhythm role of the slot.
        logic                      first;       // Bank 0 operator 0, once per sweep.
    } slot_t;

    // Subsystem result, one word per slot.
    typedef struct packed {
        logic                       valid;
        logic [BANK_NUM_WIDTH-1:0]  bank_num;
        logic [OP_NUM_WIDTH-1:0]    op_num;
        logic [PHASE_ACC_WIDTH-1:0] phase;
    } phase_out_t;

endpackage

// File: verilog/slot_sequencer.sv
`timescale 1ns/100ps

module slot_sequencer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sample_start,
    input  logic                                  rhythm_en,
    output opl3_phase_pkg::slot_t                 slot_p0,
    output logic [opl3_phase_pkg::SLOT_WIDTH-1:0] slot_idx
);

    logic                                    busy;        // Sweep in progress.
    logic                                    init;        // Reset sweep, no strobes.
    logic [opl3_phase_pkg::SLOT_WIDTH-1:0]   cnt;         // Flat slot counter.
    logic                                    in_bank1;    // Counter is past bank 0.
    logic [opl3_phase_pkg::OP_NUM_WIDTH-1:0] op_num;      // Operator within the bank.

    // ------------------------------------------------------------------------
    // Sweep control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b1;                        // The reset sweep runs right away.
            init <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (cnt == opl3_phase_pkg::SLOT_WIDTH'(opl3_phase_pkg::NUM_SLOTS - 1)) begin
                busy <= 1'b0;                    // Last slot, back to idle.
                init <= 1'b0;
                cnt  <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (sample_start) begin
            busy <= 1'b1;                        // Starts are only taken while idle.
        end
    end

    assign in_bank1 = cnt >= opl3_phase_pkg::SLOT_WIDTH'(opl3_phase_pkg::NUM_OPS_PER_BANK);
    assign op_num   = in_bank1 ?
        opl3_phase_pkg::OP_NUM_WIDTH'(cnt - opl3_phase_pkg::SLOT_WIDTH'(18)) :
        opl3_phase_pkg::OP_NUM_WIDTH'(cnt);
    assign slot_idx = cnt;

    // Slot word and rhythm map, bank 0 only.
    always_comb begin
        slot_p0          = '0;
        slot_p0.en       = busy && !init;
        slot_p0.bank_num = in_bank1;
        slot_p0.op_num   = op_num;
        slot_p0.first    = slot_p0.en && (cnt == '0);
        slot_p0.op_type  = opl3_phase_pkg::OP_NORMAL;
        if (rhythm_en && !in_bank1) begin
            case (op_num)
                5'd12, 5'd15: slot_p0.op_type = opl3_phase_pkg::OP_BASS_DRUM;
                5'd13:        slot_p0.op_type = opl3_phase_pkg::OP_HI_HAT;
                5'd14:        slot_p0.op_type = opl3_phase_pkg::OP_TOM_TOM;
                5'd16:        slot_p0.op_type = opl3_phase_pkg::OP_SNARE_DRUM;
                5'd17:        slot_p0.op_type = opl3_phase_pkg::OP_TOP_CYMBAL;
                default:      slot_p0.op_type = opl3_phase_pkg::OP_NORMAL;
            endcase
        end
    end

    // Strobed slots always address the tables downstream in range.
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        slot_p0.en |-> slot_idx < opl3_phase_pkg::SLOT_WIDTH'(opl3_phase_pkg::NUM_SLOTS))
        else $error("slot_idx %0d out of range", slot_idx);

endmodule

// File: verilog/op_config_regs.sv
`timescale 1ns/100ps

module op_config_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cfg_wr,
    input  logic [opl3_phase_pkg::SLOT_WIDTH-1:0] cfg_slot,
    input  opl3_phase_pkg::op_cfg_t               cfg_word,
    input  logic [opl3_phase_pkg::SLOT_WIDTH-1:0] rd_slot,
    output opl3_phase_pkg::op_cfg_t               rd_cfg
);

    // One configuration word per slot.
    opl3_phase_pkg::op_cfg_t cfg_mem [opl3_phase_pkg::NUM_SLOTS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < opl3_phase_pkg::NUM_SLOTS; i++) begin
                cfg_mem[i] <= '0;                // Every slot starts silent.
            end
        end else if (cfg_wr &&
                     cfg_slot < opl3_phase_pkg::SLOT_WIDTH'(opl3_phase_pkg::NUM_SLOTS)) begin
            cfg_mem[cfg_slot] <= cfg_word;
        end
    end

    // Registered read, data is there one cycle after rd_slot.
    always_ff @(posedge clk) begin
        if (cfg_wr && cfg_slot == rd_slot) begin
            rd_cfg <= cfg_word;                  // Same cycle write wins over the table.
        end else begin
            rd_cfg <= cfg_mem[rd_slot];
        end
    end

    a_cfg_slot: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_wr |-> cfg_slot < opl3_phase_pkg::SLOT_WIDTH'(opl3_phase_pkg::NUM_SLOTS))
        else $error("cfg_slot %0d out of range", cfg_slot);

endmodule

// File: verilog/phase_accumulator.sv
`timescale 1ns/100ps

module phase_accumulator (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  opl3_phase_pkg::slot_t                      slot_p0,
    input  logic [opl3_phase_pkg::SLOT_WIDTH-1:0]      slot_idx,
    input  opl3_phase_pkg::op_cfg_t                    cfg_p1,
    output opl3_phase_pkg::slot_t                      slot_p2,
    output logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] phase_acc_p2
);

    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] phase_mem [opl3_phase_pkg::NUM_SLOTS];

    logic                                       clearing;    // Reset sweep of phase_mem.
    logic [opl3_phase_pkg::SLOT_WIDTH-1:0]      clr_cnt;
    opl3_phase_pkg::slot_t                      slot_p1;
    logic [opl3_phase_pkg::SLOT_WIDTH-1:0]      idx_p1;
    logic [opl3_phase_pkg::SLOT_WIDTH-1:0]      idx_p2;      // Write back address.
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] phase_p1;    // Stored phase.
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] phase_p2;
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] shifted_p1;  // fnum << block.
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] inc_p1;
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] inc_p2;

    // ------------------------------------------------------------------------
    // Control, slot strobes and the reset sweep
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_p1  <= '0;
            slot_p2  <= '0;
            clearing <= 1'b1;                    // Runs in step with the sequencer.
            clr_cnt  <= '0;
        end else begin
            slot_p1 <= slot_p0;
            slot_p2 <= slot_p1;
            if (clearing) begin
                clr_cnt <= clr_cnt + 1'b1;
                if (clr_cnt == opl3_phase_pkg::SLOT_WIDTH'(opl3_phase_pkg::NUM_SLOTS - 1)) begin
                    clearing <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    // p1, increment from the configuration read in p0.
    assign shifted_p1 = opl3_phase_pkg::PHASE_ACC_WIDTH'(cfg_p1.fnum) << cfg_p1.block;
    assign inc_p1     = (cfg_p1.mult == '0) ? shifted_p1 >> 1 :
                        opl3_phase_pkg::PHASE_ACC_WIDTH'(shifted_p1 * cfg_p1.mult);

    always_ff @(posedge clk) begin
        idx_p1   <= slot_idx;
        phase_p1 <= phase_mem[slot_idx];         // Read in p0, held in p1.
        idx_p2   <= idx_p1;
        phase_p2 <= phase_p1;
        inc_p2   <= inc_p1;
    end

    // p2, the add wraps at 2^19 by width.
    assign phase_acc_p2 = phase_p2 + inc_p2;

    always_ff @(posedge clk) begin
        if (clearing) begin
            phase_mem[clr_cnt] <= '0;
        end else if (slot_p2.en) begin
            phase_mem[idx_p2] <= phase_acc_p2;   // Ready long before the next sweep.
        end
    end

    a_p2_follows_p0: assert property (@(posedge clk) disable iff (!rst_n)
        slot_p0.en |-> ##2 slot_p2.en)
        else $error("p2 strobe missing two cycles after p0");

endmodule

// File: verilog/calc_rhythm_phase.sv
`timescale 1ns/100ps

module calc_rhythm_phase (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  opl3_phase_pkg::slot_t                      slot_p2,
    input  logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] phase_acc_p2,
    output opl3_phase_pkg::phase_out_t                 result
);

    // Rhythm shaping works on the upper 9 bits of the phase.
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-11:0] upper_p2;
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-11:0] hh_phase;    // Latched at the hi hat.
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-11:0] tc_phase;    // Latched at the top cymbal.
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-11:0] friend_p2;
    logic [opl3_phase_pkg::RAND_NUM_WIDTH-1:0]   rand_num;    // Noise register.
    logic                                        noise_bit;
    logic                                        phase_bit_p2;
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0]  rhythm_phase_p2;

    assign upper_p2  = phase_acc_p2[opl3_phase_pkg::PHASE_ACC_WIDTH-1:10];
    assign noise_bit = rand_num[0];

    // The hi hat and top cymbal each take the other's phase.
    assign friend_p2 = (slot_p2.op_type == opl3_phase_pkg::OP_HI_HAT) ? tc_phase : hh_phase;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hh_phase <= '0;
            tc_phase <= '0;
        end else if (slot_p2.en) begin
            if (slot_p2.op_type == opl3_phase_pkg::OP_HI_HAT) begin
                hh_phase <= upper_p2;            // Same sweep for the cymbal.
            end
            if (slot_p2.op_type == opl3_phase_pkg::OP_TOP_CYMBAL) begin
                tc_phase <= upper_p2;            // Hi hat sees it one sweep later.
            end
        end
    end

    // ------------------------------------------------------------------------
    // Bit mixing
    // ------------------------------------------------------------------------
    // Own bits 7 xor 2 and bit 3, friend bits 5 xor 3.
    assign phase_bit_p2 = (upper_p2[7] ^ upper_p2[2]) | upper_p2[3] |
                          (friend_p2[5] ^ friend_p2[3]);

    always_comb begin
        rhythm_phase_p2 = phase_acc_p2;          // Melodic slots pass through.
        case (slot_p2.op_type)
            opl3_phase_pkg::OP_HI_HAT: begin
                // 34 or D0 below the mixed bit, noise picks the pattern.
                rhythm_phase_p2 = {phase_bit_p2,
                                   8'h34 << {phase_bit_p2 ^ noise_bit, 1'b0}, 10'h000};
            end
            opl3_phase_pkg::OP_SNARE_DRUM: begin
                // Bit 8 is the inverse of its own bit 8, flipped by noise.
                rhythm_phase_p2 = {(9'h100 + {upper_p2[8], 8'h00}) ^ {noise_bit, 8'h00},
                                   10'h000};
            end
            opl3_phase_pkg::OP_TOP_CYMBAL: begin
                rhythm_phase_p2 = {phase_bit_p2, 8'h80, 10'h000};
            end
            default: begin
                rhythm_phase_p2 = phase_acc_p2;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Noise and output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rand_num <= opl3_phase_pkg::RAND_NUM_WIDTH'(1);
        end else if (slot_p2.en && slot_p2.first) begin
            // One step per sample.
            rand_num <= rand_num[0] ? (rand_num ^ opl3_phase_pkg::RAND_POLYNOMIAL) >> 1 :
                                      rand_num >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid    <= slot_p2.en;
            result.bank_num <= slot_p2.bank_num;
            result.op_num   <= slot_p2.op_num;
            result.phase    <= rhythm_phase_p2;
        end
    end

    // The sequencer only marks percussion slots in bank 0.
    a_rhythm_bank0: assert property (@(posedge clk) disable iff (!rst_n)
        slot_p2.en && slot_p2.op_type != opl3_phase_pkg::OP_NORMAL |-> slot_p2.bank_num == '0)
        else $error("rhythm type in bank %0d", slot_p2.bank_num);

endmodule

// File: verilog/opl3_phase_top.sv
`timescale 1ns/100ps

module opl3_phase_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sample_start,   // One pulse per sample.
    input  logic                                  rhythm_en,
    input  logic                                  cfg_wr,
    input  logic [opl3_phase_pkg::SLOT_WIDTH-1:0] cfg_slot,
    input  opl3_phase_pkg::op_cfg_t               cfg_word,
    output opl3_phase_pkg::phase_out_t            result          // Three cycles after p0.
);

    opl3_phase_pkg::slot_t                      slot_p0;
    opl3_phase_pkg::slot_t                      slot_p2;
    logic [opl3_phase_pkg::SLOT_WIDTH-1:0]      slot_idx;
    opl3_phase_pkg::op_cfg_t                    cfg_p1;
    logic [opl3_phase_pkg::PHASE_ACC_WIDTH-1:0] phase_acc_p2;

    slot_sequencer u_slot_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .rhythm_en    (rhythm_en),
        .slot_p0      (slot_p0),
        .slot_idx     (slot_idx)
    );

    // The sweep reads the configuration in p0 for use in p1.
    op_config_regs u_op_config_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_wr   (cfg_wr),
        .cfg_slot (cfg_slot),
        .cfg_word (cfg_word),
        .rd_slot  (slot_idx),
        .rd_cfg   (cfg_p1)
    );

    phase_accumulator u_phase_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_p0      (slot_p0),
        .slot_idx     (slot_idx),
        .cfg_p1       (cfg_p1),
        .slot_p2      (slot_p2),
        .phase_acc_p2 (phase_acc_p2)
    );

    calc_rhythm_phase u_calc_rhythm_phase (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_p2      (slot_p2),
        .phase_acc_p2 (phase_acc_p2),
        .result       (result)
    );

endmodule

// File: dv/opl3_phase_tb.sv
`timescale 1ns/100ps

module opl3_phase_tb;

    localparam int CLK_PERIOD      = 40;                        // ns.
    localparam int NUM_SWEEPS      = 40;
    localparam int WATCHDOG_CYCLES = NUM_SWEEPS * 45 + 400;     // Sweeps plus setup margin.
    localparam int PW              = opl3_phase_pkg::PHASE_ACC_WIDTH;
    localparam int NW              = opl3_phase_pkg::RAND_NUM_WIDTH;

    logic                                  clk = 1'b0;
    logic                                  rst_n;
    logic                                  sample_start;
    logic                                  rhythm_en;
    logic                                  cfg_wr;
    logic [opl3_phase_pkg::SLOT_WIDTH-1:0] cfg_slot;
    opl3_phase_pkg::op_cfg_t               cfg_word;
    opl3_phase_pkg::phase_out_t            result;

    // Reference model that the stimulus advances once per sample.
    opl3_phase_pkg::op_cfg_t model_cfg   [opl3_phase_pkg::NUM_SLOTS];
    logic [PW-1:0]           model_phase [opl3_phase_pkg::NUM_SLOTS];   // Phase after the sweep.
    logic [NW-1:0]           model_noise;
    logic                    model_rhythm;

    // Expected slot stream rebuilt from the sweep timing rules.
    int         init_left;                   // Reset sweep cycles still to go.
    logic       cur_en;                      // Expected strobe at p0.
    logic [5:0] cur_idx;
    int         left;                        // Slots left after the current one.
    logic [2:0] v_pipe;                      // Strobe delayed by three clocks.
    logic [5:0] idx_pipe [3];

    logic          exp_valid;
    logic [5:0]    exp_idx;
    logic          exp_bank;
    logic [4:0]    exp_op;
    logic [PW-1:0] exp_model;
    logic [PW-1:0] exp_phase;
    logic          own_bit;                  // Own half of the hi hat and cymbal mix.
    logic [7:0]    hh_low;
    logic          phase_ok;

    int error_count = 0;
    int valid_seen  = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    opl3_phase_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .rhythm_en    (rhythm_en),
        .cfg_wr       (cfg_wr),
        .cfg_slot     (cfg_slot),
        .cfg_word     (cfg_word),
        .result       (result)
    );

    // ------------------------------------------------------------------------
    // Reference helpers
    // ------------------------------------------------------------------------
    function automatic logic [PW-1:0] increment_of(input opl3_phase_pkg::op_cfg_t cfg);
        int unsigned shifted;
        int unsigned inc;
        shifted = int'(cfg.fnum) << cfg.block;              // Block is an octave shift.
        if (cfg.mult == 0) begin
            inc = shifted / 2;                               // Multiple code 0 is one half.
        end else begin
            inc = shifted * cfg.mult;
        end
        return PW'(inc);                                     // Wraps at 2^19.
    endfunction

    function automatic logic [NW-1:0] next_noise(input logic [NW-1:0] r);
        logic [NW-1:0] stepped;
        stepped = r >> 1;
        if (r[0]) begin
            stepped = stepped ^ (opl3_phase_pkg::RAND_POLYNOMIAL >> 1);   // Feedback taps.
        end
        return stepped;
    endfunction

    function automatic opl3_phase_pkg::op_cfg_t random_cfg();
        opl3_phase_pkg::op_cfg_t word;
        word.fnum  = opl3_phase_pkg::FNUM_WIDTH'($urandom);
        word.block = opl3_phase_pkg::BLOCK_WIDTH'($urandom);
        word.mult  = opl3_phase_pkg::MULT_WIDTH'($urandom);
        return word;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count++;
        $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
    endtask

    // ------------------------------------------------------------------------
    // Expected stream and checks
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_left <= 36;                                 // Reset sweep ignores starts.
            cur_en    <= 1'b0;
            cur_idx   <= '0;
            left      <= 0;
            v_pipe    <= '0;
            for (int i = 0; i < 3; i++) begin
                idx_pipe[i] <= '0;
            end
        end else begin
            if (init_left != 0) begin
                init_left <= init_left - 1;
            end
            if (cur_en && left != 0) begin
                cur_idx <= cur_idx + 1'b1;
                left    <= left - 1;
            end else if (cur_en) begin
                cur_en <= 1'b0;                              // A start here is too early.
            end else if (sample_start && init_left == 0) begin
                cur_en  <= 1'b1;
                cur_idx <= '0;
                left    <= 35;
            end
            v_pipe      <= {v_pipe[1:0], cur_en};
            idx_pipe[0] <= cur_idx;
            idx_pipe[1] <= idx_pipe[0];
            idx_pipe[2] <= idx_pipe[1];
        end
    end

    always_comb begin
        exp_valid = v_pipe[2];
        exp_idx   = idx_pipe[2];
        exp_bank  = exp_idx >= 6'd18;
        exp_op    = exp_bank ? 5'(exp_idx - 6'd18) : 5'(exp_idx);
        exp_model = model_phase[exp_idx];
        exp_phase = exp_model;
        own_bit   = (exp_model[17] ^ exp_model[12]) | exp_model[13];
        hh_low    = (result.phase[18] ^ model_noise[0]) ? 8'hd0 : 8'h34;
        phase_ok  = result.phase == exp_model;               // Melodic and bank 1 slots.
        if (model_rhythm) begin
            case (exp_idx)
                6'd13: begin
                    phase_ok = result.phase[9:0] == '0 && result.phase[17:10] == hh_low &&
                               (result.phase[18] || !own_bit);
                end
                6'd16: begin
                    // Adding 100h to the own bit 8 and xoring the noise leaves only bit 8.
                    exp_phase = {~exp_model[18] ^ model_noise[0], 18'h00000};
                    phase_ok  = result.phase == exp_phase;
                end
                6'd17: begin
                    phase_ok = result.phase[9:0] == '0 && result.phase[17:10] == 8'h80 &&
                               (result.phase[18] || !own_bit);
                end
                default: begin
                end
            endcase
        end
    end

    always @(negedge clk) begin
        if (rst_n && result.valid) begin
            valid_seen++;                                    // Outputs are settled here.
        end
    end

    a_valid: assert property (@(negedge clk) disable iff (!rst_n) result.valid == exp_valid)
        else report_value("result.valid", 32'(exp_valid), 32'(result.valid));
    a_bank: assert property (@(negedge clk) disable iff (!rst_n)
        result.valid |-> result.bank_num == exp_bank)
        else report_value("result.bank_num", 32'(exp_bank), 32'(result.bank_num));
    a_op: assert property (@(negedge clk) disable iff (!rst_n)
        result.valid |-> result.op_num == exp_op)
        else report_value("result.op_num", 32'(exp_op), 32'(result.op_num));
    a_phase: assert property (@(negedge clk) disable iff (!rst_n) result.valid |-> phase_ok)
        else report_value("result.phase", 32'(exp_phase), 32'(result.phase));

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic step_cycle();
        @(posedge clk);
        #1;                                                  // Drive just after the edge.
    endtask

    task automatic write_cfg(input logic [5:0] slot, input opl3_phase_pkg::op_cfg_t word);
        cfg_wr          = 1'b1;
        cfg_slot        = slot;
        cfg_word        = word;
        model_cfg[slot] = word;                              // Used from the next sweep on.
        step_cycle();
        cfg_wr          = 1'b0;
    endtask

    task automatic run_sweep(input logic rhythm, input logic stray);
        rhythm_en    = rhythm;                               // Held for the whole sweep.
        model_rhythm = rhythm;
        model_noise  = next_noise(model_noise);              // Noise steps at the first slot.
        for (int i = 0; i < opl3_phase_pkg::NUM_SLOTS; i++) begin
            model_phase[i] = model_phase[i] + increment_of(model_cfg[i]);
        end
        sample_start = 1'b1;
        step_cycle();
        sample_start = 1'b0;
        while (!result.valid) begin
            step_cycle();
        end
        if (stray) begin
            repeat (5) step_cycle();
            sample_start = 1'b1;                             // This start comes mid sweep.
            step_cycle();
            sample_start = 1'b0;
        end
        while (result.valid) begin
            step_cycle();
        end
    endtask

    initial begin
        logic [5:0]  slot;
        void'($urandom(69850));                              // Fixed seed for the stimulus.
        rst_n        = 1'b0;
        sample_start = 1'b0;
        rhythm_en    = 1'b0;
        cfg_wr       = 1'b0;
        cfg_slot     = '0;
        cfg_word     = '0;
        model_noise  = NW'(1);
        model_rhythm = 1'b0;
        for (int i = 0; i < opl3_phase_pkg::NUM_SLOTS; i++) begin
            model_phase[i] = '0;
            model_cfg[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (40) step_cycle();                            // Let the reset sweep finish.
        for (int i = 0; i < opl3_phase_pkg::NUM_SLOTS; i++) begin
            write_cfg(6'(i), random_cfg());
        end
        write_cfg(6'd5, '{fnum: 10'h3ff, block: 3'd7, mult: 4'd0});    // Half multiple.
        write_cfg(6'd35, '{fnum: 10'h3ff, block: 3'd7, mult: 4'd15});  // Wraps each sweep.
        for (int s = 0; s < NUM_SWEEPS; s++) begin
            if (s % 3 == 1) begin
                slot = 6'($urandom % opl3_phase_pkg::NUM_SLOTS);
                write_cfg(slot, random_cfg());
            end
            run_sweep(s >= 12 && s < 32, s % 7 == 3);
        end
        repeat (4) step_cycle();
        if (valid_seen != NUM_SWEEPS * opl3_phase_pkg::NUM_SLOTS) begin
            report_value("result.valid count", 32'(NUM_SWEEPS * opl3_phase_pkg::NUM_SLOTS),
                         32'(valid_seen));
        end
        $display("Errors: %0d, results checked: %0d", error_count, valid_seen);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Ends a run whose sweeps stop producing results.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: opl3_phase_top.f
verilog/opl3_phase_pkg.sv
verilog/slot_sequencer.sv
verilog/op_config_regs.sv
verilog/phase_accumulator.sv
verilog/calc_rhythm_phase.sv
verilog/opl3_phase_top.sv
dv/opl3_phase_tb.sv

// File: Makefile
# Verilator build and run of the phase generation testbench.
VERILATOR ?= verilator
TOP       ?= opl3_phase_tb
RTL_TOP   ?= opl3_phase_top
FILELIST  ?= opl3_phase_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
